//--- Makefile
# Verilator build for the audio TX front end
TOP := AudioTxTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)
	verilator --lint-only --timing -f filelist.f --top-module AudioTxTop

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+verilog
verilog/UsiBusPkg.sv
verilog/SfmPkg.sv
verilog/SfmReqIf.sv
verilog/AudioTxCsr.sv
verilog/SfmPageReader.sv
verilog/SfmSpiArbiter.sv
verilog/SfmSpiMaster.sv
verilog/AudioTxTop.sv
tb/AudioTx_properties.sv
tb/AudioTxTb.sv

//--- tb/AudioTxTb.sv
// Audio TX testbench with a serial flash model, USI bus access and stream checks
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module AudioTxTb import UsiBusPkg::*, SfmPkg::*; ();

	localparam int WaitMax = 8000;   // Cycles allowed per wait loop

	logic                iSCLK;
	logic                iSRST;
	usiWord_t            usiWd;
	usiAdrs_t            usiAdrs;
	usiWord_t            usiRd;
	logic                spiSck;
	logic                spiCs;
	logic                spiMosi;
	logic                spiMiso;
	sfmSample_t          sampleData [`SFM_NUM];
	logic [`SFM_NUM-1:0] sampleValid;
	logic [`SFM_NUM-1:0] sampleReady;

	sfmSample_t  got0 [$];     // Accepted samples of channel 0
	sfmSample_t  got1 [$];     // Accepted samples of channel 1
	logic        readyRandom;
	logic [15:0] lfsr;
	int          errCnt;
	int          testCnt;
	int          testFailCnt;
	int          flashBits;    // Bits seen in the current flash transaction
	logic [23:0] flashCmdAdrs;
	logic [15:0] flashOut;

	AudioTxTop DUT (.*);

	initial
	begin
		iSCLK = 1'b0;
		forever #2 iSCLK = ~iSCLK;
	end

	// Overall run time limit
	initial
	begin
		#2000000;
		$display("Simulation ran past its time limit without finishing");
		$display("CHECKS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Reference rules
	// --------------------------------------------------
	function automatic logic [7:0] flashByte(input sfmAdrs_t a);
		return a[7:0] ^ 8'h5A;
	endfunction

	function automatic sfmSample_t expSample(input sfmAdrs_t a);
		return {flashByte(a + 16'd1), flashByte(a)};   // Low byte at the even address
	endfunction

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int gotSize(input int ch);
		return (ch == 0) ? got0.size() : got1.size();
	endfunction

	function automatic sfmSample_t gotAt(input int ch, input int i);
		return (ch == 0) ? got0[i] : got1[i];
	endfunction

	function automatic int errTotal();
		return errCnt + DUT.uProps.failCnt;
	endfunction

	// --------------------------------------------------
	// Flash model in SPI mode 0
	// --------------------------------------------------
	always @(posedge spiSck or negedge spiCs)
	begin
		if (!spiSck)
			flashBits = 0;                  // CS just fell
		else if (!spiCs)
		begin
			flashCmdAdrs = {flashCmdAdrs[22:0], spiMosi};
			flashBits++;
			if (flashBits == 24)
			begin
				checkEq("flash command", 32'(flashCmdAdrs[23:16]), 32'(`SFM_READ_CMD));
				flashOut = {flashByte(flashCmdAdrs[15:0]), flashByte(flashCmdAdrs[15:0] + 16'd1)};
			end
		end
	end

	always @(negedge spiSck)
		if (flashBits >= 24 && flashBits < 40)
			spiMiso <= flashOut[39 - flashBits];   // MSB first

	// Ready pattern with one LFSR step per bit
	always @(posedge iSCLK)
	begin
		if (readyRandom)
		begin
			for (int ch = 0; ch < `SFM_NUM; ch++)
			begin
				sampleReady[ch] <= lfsr[0];
				lfsr = lfsrNext(lfsr);
			end
		end
		else
			sampleReady <= '1;
	end

	// Stream capture at the falling edge
	always @(negedge iSCLK)
	begin
		if (!iSRST && sampleValid[0] && sampleReady[0])
			got0.push_back(sampleData[0]);
		if (!iSRST && sampleValid[1] && sampleReady[1])
			got1.push_back(sampleData[1]);
	end

	// --------------------------------------------------
	// Bus access and checks
	// --------------------------------------------------
	task automatic writeReg(input usiCsrOfs_t ofs, input usiWord_t data);
		@(posedge iSCLK);
		usiAdrs <= usiAdrs_t'(ofs) | (usiAdrs_t'(1) << `USI_WE_BIT);
		usiWd   <= data;
		@(posedge iSCLK);
		usiAdrs <= '0;
	endtask

	task automatic readReg(input usiCsrOfs_t ofs, output usiWord_t data);
		@(posedge iSCLK);
		usiAdrs <= usiAdrs_t'(ofs);
		@(posedge iSCLK);
		@(negedge iSCLK);                  // Registered read data is settled here
		data = usiRd;
	endtask

	task automatic checkEq(input string what, input logic [31:0] gotVal, input logic [31:0] expVal);
		if (gotVal !== expVal)
		begin
			$display("FAIL at %t: %s is %h, expected %h", $realtime, what, gotVal, expVal);
			errCnt++;
		end
	endtask

	task automatic writeCheck(input usiCsrOfs_t ofs, input usiWord_t data, input usiWord_t expVal);
		usiWord_t rd;
		writeReg(ofs, data);
		readReg(ofs, rd);
		checkEq($sformatf("readback of offset %h", ofs), rd, expVal);
	endtask

	task automatic waitSamples(input int ch, input int count);
		int n;
		n = 0;
		while (gotSize(ch) < count && n < WaitMax)
		begin
			@(negedge iSCLK);
			n++;
		end
		if (gotSize(ch) < count)
		begin
			$display("Timeout: channel %0d gave %0d of %0d samples", ch, gotSize(ch), count);
			errCnt++;
		end
	endtask

	// Poll a register until the masked value matches and optionally watch ADRS0
	task automatic pollReg(input usiCsrOfs_t ofs, input usiWord_t mask, input usiWord_t expVal,
		input logic watch, input usiWord_t lo, input usiWord_t hi);
		usiWord_t rd;
		usiWord_t adrs;
		int n;
		n = 0;
		readReg(ofs, rd);
		while ((rd & mask) != expVal && n < WaitMax / 4)
		begin
			if (watch)
			begin
				readReg(`CSR_ADRS0, adrs);
				if (adrs < lo || adrs > hi)
				begin
					$display("FAIL at %t: ADRS0 is %h, outside %h to %h", $realtime, adrs, lo, hi);
					errCnt++;
				end
			end
			readReg(ofs, rd);
			n++;
		end
		if ((rd & mask) != expVal)
		begin
			$display("Timeout: register %h never reached %h under mask %h", ofs, expVal, mask);
			errCnt++;
		end
	endtask

	task automatic checkStream(input int ch, input sfmAdrs_t start, input int count, input int period);
		sfmAdrs_t a;
		for (int i = 0; i < count; i++)
		begin
			a = start + sfmAdrs_t'(2 * (i % period));
			if (i >= gotSize(ch))
			begin
				$display("Channel %0d is missing sample %0d of %0d", ch, i, count);
				errCnt++;
				break;
			end
			checkEq($sformatf("channel %0d sample %0d", ch, i), 32'(gotAt(ch, i)), 32'(expSample(a)));
		end
	endtask

	task automatic clearStreams();
		got0.delete();
		got1.delete();
	endtask

	task automatic endTest(input string name, input int errBefore);
		testCnt++;
		if (errTotal() == errBefore)
			$display("Test %0d, %s: ok", testCnt, name);
		else
		begin
			testFailCnt++;
			$display("Test %0d, %s: %0d errors", testCnt, name, errTotal() - errBefore);
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial
	begin
		usiWord_t rd;
		int errBefore;
		$timeformat(-9, 1, " ns", 10);
		iSRST       = 1'b1;
		usiWd       = '0;
		usiAdrs     = '0;
		sampleReady = '0;
		spiMiso     = 1'b0;
		readyRandom = 1'b0;
		lfsr        = 16'd18;
		errCnt      = 0;
		testCnt     = 0;
		testFailCnt = 0;
		repeat (3) @(posedge iSCLK);
		iSRST <= 1'b0;

		errBefore = errTotal();
		readReg(`CSR_DIV, rd);
		checkEq("DIV after reset", rd, 32'h0000_0404);
		readReg(`CSR_CSHOLD, rd);
		checkEq("CSHOLD after reset", rd, 32'h0000_1414);
		writeCheck(`CSR_START0, 32'h1234_ABCD, 32'h0000_ABCD);
		writeCheck(`CSR_END1, 32'hFFFF_0022, 32'h0000_0022);
		writeCheck(`CSR_DIV, 32'h1234_5601, 32'h0000_5601);
		writeCheck(`CSR_CYCLE, 32'hFFFF_FFFE, 32'h0000_0002);
		endTest("register reset and readback", errBefore);

		// Fast SPI clock and short CS hold for the playback tests
		writeReg(`CSR_CYCLE, 32'h0);
		writeReg(`CSR_DIV, 32'h0);
		writeReg(`CSR_CSHOLD, 32'h0202);

		errBefore = errTotal();
		clearStreams();
		writeReg(`CSR_START0, 32'h0010);
		writeReg(`CSR_END0, 32'h001E);
		writeReg(`CSR_EN, 32'h1);
		waitSamples(0, 8);
		pollReg(`CSR_DONE, 32'h1, 32'h1, 1'b0, '0, '0);
		checkStream(0, 16'h0010, 8, 8);
		checkEq("channel 0 sample count", 32'(got0.size()), 32'd8);
		readReg(`CSR_EN, rd);
		checkEq("EN after page", rd, 32'h0);
		writeReg(`CSR_DONE, 32'h1);
		readReg(`CSR_DONE, rd);
		checkEq("DONE after clear", rd, 32'h0);
		endTest("single channel playback", errBefore);

		errBefore = errTotal();
		clearStreams();
		writeReg(`CSR_CYCLE, 32'h1);
		writeReg(`CSR_EN, 32'h1);
		waitSamples(0, 9);
		checkStream(0, 16'h0010, 9, 8);
		checkEq("ninth sample against the window start", 32'(gotAt(0, 8)),
			32'(expSample(16'h0010)));
		writeReg(`CSR_CYCLE, 32'h0);
		pollReg(`CSR_EN, 32'h1, 32'h0, 1'b0, '0, '0);   // Stops at the next page end
		writeReg(`CSR_DONE, 32'h1);
		endTest("cycle mode restart", errBefore);

		errBefore = errTotal();
		clearStreams();
		writeReg(`CSR_START0, 32'h0100);
		writeReg(`CSR_END0, 32'h010E);
		writeReg(`CSR_START1, 32'h2000);
		writeReg(`CSR_END1, 32'h2016);
		writeReg(`CSR_EN, 32'h3);
		pollReg(`CSR_DONE, 32'h3, 32'h3, 1'b0, '0, '0);
		checkStream(0, 16'h0100, 8, 8);
		checkStream(1, 16'h2000, 12, 12);
		checkEq("channel 0 sample count", 32'(got0.size()), 32'd8);
		checkEq("channel 1 sample count", 32'(got1.size()), 32'd12);
		writeReg(`CSR_DONE, 32'h3);
		endTest("two channels on shared flash", errBefore);

		errBefore = errTotal();
		clearStreams();
		readyRandom <= 1'b1;
		writeReg(`CSR_START0, 32'h0200);
		writeReg(`CSR_END0, 32'h0226);
		writeReg(`CSR_START1, 32'h3000);
		writeReg(`CSR_END1, 32'h3010);
		writeReg(`CSR_EN, 32'h3);
		pollReg(`CSR_DONE, 32'h3, 32'h3, 1'b1, 32'h0200, 32'h0228);
		readyRandom <= 1'b0;
		checkStream(0, 16'h0200, 20, 20);
		checkStream(1, 16'h3000, 9, 9);
		checkEq("channel 0 sample count", 32'(got0.size()), 32'd20);
		checkEq("channel 1 sample count", 32'(got1.size()), 32'd9);
		endTest("back-pressure", errBefore);

		$display("Tests run: %0d, failed: %0d, data errors: %0d, assertion failures: %0d",
			testCnt, testFailCnt, errCnt, DUT.uProps.failCnt);
		if (errTotal() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb/AudioTx_properties.sv
// Protocol assertions for the audio TX front end bound into the top level
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module AudioTx_properties import SfmPkg::*; (
	input logic                iSCLK,
	input logic                iSRST,
	input sfmSample_t          sampleData [`SFM_NUM],
	input logic [`SFM_NUM-1:0] sampleValid,
	input logic [`SFM_NUM-1:0] sampleReady,
	input logic                spiSck,
	input logic                spiCs,
	input logic [`SFM_NUM-1:0] gnt,        // Arbiter one-hot owner
	input logic [`SFM_NUM-1:0] reqValid,   // Reader request valids
	input logic [`SFM_NUM-1:0] inFlight,   // Readers waiting on a sample
	input logic                spiValid,
	input logic                spiReady
);

	int failCnt = 0;   // Failed assertion count

	logic [`SFM_NUM-1:0] reqTaken;

	// Request accepted at the engine port
	assign reqTaken = gnt & {`SFM_NUM{spiValid & spiReady}};

	// --------------------------------------------------
	// Per channel
	// --------------------------------------------------
	for (genvar g = 0; g < `SFM_NUM; g++)
	begin : gCh
		aSampleHold: assert property (@(posedge iSCLK) disable iff (iSRST)
			sampleValid[g] && !sampleReady[g] |=> sampleValid[g] && $stable(sampleData[g]))
		else
		begin
			failCnt++;
			$error("Channel %0d sample changed or dropped before ready", g);
		end

		aReqHold: assert property (@(posedge iSCLK) disable iff (iSRST)
			reqValid[g] && !reqTaken[g] |=> reqValid[g])
		else
		begin
			failCnt++;
			$error("Channel %0d request valid dropped before ready", g);
		end
	end

	// --------------------------------------------------
	// Shared flash port
	// --------------------------------------------------
	aGrantOneHot: assert property (@(posedge iSCLK) disable iff (iSRST) $onehot0(inFlight))
	else
	begin
		failCnt++;
		$error("More than one reader holds the flash engine");
	end

	aSckIdle: assert property (@(posedge iSCLK) disable iff (iSRST) spiCs |-> !spiSck)
	else
	begin
		failCnt++;
		$error("SPI clock high while chip select is high");
	end

endmodule

bind AudioTxTop AudioTx_properties uProps (
	.iSCLK, .iSRST, .sampleData, .sampleValid, .sampleReady, .spiSck, .spiCs,
	.gnt(uArb.gnt), .reqValid(uArb.reqValid),
	.inFlight({gCh[1].uReader.waitQ, gCh[0].uReader.waitQ}),
	.spiValid(spiReq.valid), .spiReady(spiReq.ready)
);

//--- verilog/AudioTxCsr.sv
// Audio TX register file with write decode, registered readback and done capture
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module AudioTxCsr import UsiBusPkg::*, SfmPkg::*; (
	input  logic                iSCLK,
	input  logic                iSRST,
	input  usiWord_t            usiWd,
	input  usiAdrs_t            usiAdrs,
	input  logic [`SFM_NUM-1:0] pageDone,
	input  sfmAdrs_t            curAdrs [`SFM_NUM],
	output usiWord_t            usiRd,
	output sfmCfg_t             cfg [`SFM_NUM]
);

	// Per-channel register offset from a channel 0 base
	function automatic usiCsrOfs_t chOfs(input usiCsrOfs_t base, input int ch, input int stride);
		return usiCsrOfs_t'(int'(base) + ch * stride);
	endfunction

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------
	logic [`SFM_NUM-1:0]   enQ;
	logic [`SFM_NUM-1:0]   cycleQ;
	logic [`SFM_NUM*8-1:0] divQ;       // One byte per channel
	logic [`SFM_NUM*8-1:0] csHoldQ;    // One byte per channel
	logic [`SFM_NUM-1:0]   doneQ;      // Sticky page done
	sfmAdrs_t              startQ [`SFM_NUM];
	sfmAdrs_t              endQ [`SFM_NUM];

	usiCsrOfs_t            ofs;
	logic                  wr;
	logic                  wrEn, wrCycle, wrDiv, wrCsHold, wrDone;
	logic [`SFM_NUM-1:0]   wrStart, wrEnd;
	usiWord_t              rdMux;

	assign ofs = usiAdrs[7:0];
	assign wr  = usiAdrs[`USI_WE_BIT];

	// Write strobes
	always_comb
	begin
		wrEn     = wr && (ofs == `CSR_EN);
		wrCycle  = wr && (ofs == `CSR_CYCLE);
		wrDiv    = wr && (ofs == `CSR_DIV);
		wrCsHold = wr && (ofs == `CSR_CSHOLD);
		wrDone   = wr && (ofs == `CSR_DONE);
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			wrStart[i] = wr && (ofs == chOfs(`CSR_START0, i, 8));
			wrEnd[i]   = wr && (ofs == chOfs(`CSR_END0, i, 8));
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			enQ     <= '0;
			cycleQ  <= '0;
			divQ    <= {`SFM_NUM{`DIV_RST}};
			csHoldQ <= {`SFM_NUM{`CSHOLD_RST}};
			doneQ   <= '0;
			for (int i = 0; i < `SFM_NUM; i++)
			begin
				startQ[i] <= '0;
				endQ[i]   <= '0;
			end
		end
		else
		begin
			if (wrCycle)  cycleQ  <= usiWd[`SFM_NUM-1:0];
			if (wrDiv)    divQ    <= usiWd[`SFM_NUM*8-1:0];
			if (wrCsHold) csHoldQ <= usiWd[`SFM_NUM*8-1:0];
			for (int i = 0; i < `SFM_NUM; i++)
			begin
				// Page end wins over a CPU write, cycle bit decides the rerun
				if (pageDone[i])  enQ[i] <= cycleQ[i];
				else if (wrEn)    enQ[i] <= usiWd[i];
				if (pageDone[i])  doneQ[i] <= 1'b1;
				else if (wrDone)  doneQ[i] <= 1'b0;
				if (wrStart[i])   startQ[i] <= usiWd[`SFM_ADRS_W-1:0];
				if (wrEnd[i])     endQ[i]   <= usiWd[`SFM_ADRS_W-1:0];
			end
		end
	end

	// --------------------------------------------------
	// Readback, one cycle after the address
	// --------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (ofs)
			`CSR_EN:     rdMux = usiWord_t'(enQ);
			`CSR_CYCLE:  rdMux = usiWord_t'(cycleQ);
			`CSR_DIV:    rdMux = usiWord_t'(divQ);
			`CSR_CSHOLD: rdMux = usiWord_t'(csHoldQ);
			`CSR_DONE:   rdMux = usiWord_t'(doneQ);
			default:
			begin
				for (int i = 0; i < `SFM_NUM; i++)
				begin
					if (ofs == chOfs(`CSR_START0, i, 8)) rdMux = usiWord_t'(startQ[i]);
					if (ofs == chOfs(`CSR_END0, i, 8))   rdMux = usiWord_t'(endQ[i]);
					if (ofs == chOfs(`CSR_ADRS0, i, 4))  rdMux = usiWord_t'(curAdrs[i]);  // Live
				end
			end
		endcase
	end

	always_ff @(posedge iSCLK)
		usiRd <= rdMux;

	// Channel setup out to the readers
	always_comb
	begin
		for (int i = 0; i < `SFM_NUM; i++)
		begin
			cfg[i].en        = enQ[i];
			cfg[i].div       = divQ[i*8 +: 8];
			cfg[i].csHold    = csHoldQ[i*8 +: 8];
			cfg[i].startAdrs = startQ[i];
			cfg[i].endAdrs   = endQ[i];
		end
	end

endmodule

//--- verilog/AudioTxTop.sv
// Audio TX top level joining the CSR, page readers, arbiter and SPI engine
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module AudioTxTop import UsiBusPkg::*, SfmPkg::*; (
	input  logic                iSCLK,
	input  logic                iSRST,
	// USI bus
	input  usiWord_t            usiWd,
	input  usiAdrs_t            usiAdrs,
	output usiWord_t            usiRd,
	// Serial flash
	output logic                spiSck,
	output logic                spiCs,
	output logic                spiMosi,
	input  logic                spiMiso,
	// Sample streams
	output sfmSample_t          sampleData [`SFM_NUM],
	output logic [`SFM_NUM-1:0] sampleValid,
	input  logic [`SFM_NUM-1:0] sampleReady
);

	sfmCfg_t             cfg [`SFM_NUM];
	logic [`SFM_NUM-1:0] pageDone;
	sfmAdrs_t            curAdrs [`SFM_NUM];

	SfmReqIf rdReq [`SFM_NUM] ();   // Reader to arbiter
	SfmReqIf spiReq ();             // Arbiter to engine

	AudioTxCsr uCsr (
		.iSCLK, .iSRST, .usiWd, .usiAdrs, .pageDone, .curAdrs, .usiRd, .cfg
	);

	for (genvar g = 0; g < `SFM_NUM; g++)
	begin : gCh
		SfmPageReader uReader (
			.iSCLK, .iSRST, .cfg(cfg[g]), .sampleReady(sampleReady[g]),
			.pageDone(pageDone[g]), .curAdrs(curAdrs[g]),
			.sampleData(sampleData[g]), .sampleValid(sampleValid[g]), .req(rdReq[g])
		);
	end

	SfmSpiArbiter uArb (.iSCLK, .iSRST, .req(rdReq), .spi(spiReq));

	SfmSpiMaster uSpi (.iSCLK, .iSRST, .spiMiso, .spiSck, .spiCs, .spiMosi, .req(spiReq));

endmodule

//--- verilog/AudioTx_consts.svh
// Audio playback front end constants: channel count, CSR map and reset values
`ifndef AUDIOTX_CONSTS_SVH
`define AUDIOTX_CONSTS_SVH

`define SFM_NUM      2      // Flash channels
`define SFM_ADRS_W   16     // Flash byte address width

// CSR offsets within the block
`define CSR_EN       8'h04
`define CSR_CYCLE    8'h08
`define CSR_DIV      8'h0C
`define CSR_CSHOLD   8'h10
`define CSR_DONE     8'h30
`define CSR_START0   8'h60
`define CSR_END0     8'h64
`define CSR_START1   8'h68
`define CSR_END1     8'h6C
`define CSR_ADRS0    8'hA0
`define CSR_ADRS1    8'hA4

`define USI_WE_BIT   30     // Set in usiAdrs for a write cycle
`define DIV_RST      8'd4
`define CSHOLD_RST   8'd20
`define SFM_READ_CMD 8'h03  // Serial flash READ opcode

`endif

//--- verilog/SfmPageReader.sv
// Page reader that walks one address window and streams 16-bit samples
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module SfmPageReader import SfmPkg::*; (
	input  logic       iSCLK,
	input  logic       iSRST,
	input  sfmCfg_t    cfg,
	input  logic       sampleReady,
	output logic       pageDone,
	output sfmAdrs_t   curAdrs,
	output sfmSample_t sampleData,
	output logic       sampleValid,
	SfmReqIf.requester req
);

	logic                 busyQ;        // Walking the window
	logic                 reqValidQ;
	logic                 waitQ;        // Request taken, sample in flight
	logic                 enPrevQ;
	logic                 checkQ;       // Cycle after pageDone
	logic                 pageDoneQ;
	logic                 sampleValidQ;
	sfmAdrs_t             adrsQ;
	sfmSample_t           sampleQ;
	logic [`SFM_ADRS_W:0] nextAdrs;     // One extra bit so the window top cannot wrap
	logic                 lastSample;
	logic                 startPage;

	assign nextAdrs   = {1'b0, adrsQ} + {{(`SFM_ADRS_W-1){1'b0}}, 2'd2};
	assign lastSample = nextAdrs > {1'b0, cfg.endAdrs};

	// Enable edge, or enable still set right after a page in cycle mode
	assign startPage = ~busyQ & ~pageDoneQ & cfg.en & (~enPrevQ | checkQ);

	assign req.valid  = reqValidQ;
	assign req.adrs   = adrsQ;
	assign req.div    = cfg.div;
	assign req.csHold = cfg.csHold;

	assign pageDone    = pageDoneQ;
	assign curAdrs     = adrsQ;
	assign sampleData  = sampleQ;
	assign sampleValid = sampleValidQ;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			busyQ        <= 1'b0;
			reqValidQ    <= 1'b0;
			waitQ        <= 1'b0;
			enPrevQ      <= 1'b0;
			checkQ       <= 1'b0;
			pageDoneQ    <= 1'b0;
			sampleValidQ <= 1'b0;
			adrsQ        <= '0;
		end
		else
		begin
			enPrevQ   <= cfg.en;
			checkQ    <= pageDoneQ;
			pageDoneQ <= 1'b0;
			if (startPage)
			begin
				busyQ     <= 1'b1;
				adrsQ     <= cfg.startAdrs;
				reqValidQ <= 1'b1;
			end
			if (reqValidQ && req.ready)
			begin
				reqValidQ <= 1'b0;
				waitQ     <= 1'b1;
			end
			if (waitQ && req.done)
			begin
				waitQ        <= 1'b0;
				sampleValidQ <= 1'b1;
			end
			// Next request only once the current sample is gone
			if (sampleValidQ && sampleReady)
			begin
				sampleValidQ <= 1'b0;
				if (lastSample)
				begin
					busyQ     <= 1'b0;
					pageDoneQ <= 1'b1;
				end
				else
				begin
					adrsQ     <= nextAdrs[`SFM_ADRS_W-1:0];
					reqValidQ <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iSCLK)
		if (waitQ && req.done) sampleQ <= req.rdata;

endmodule

//--- verilog/SfmPkg.sv
// Serial flash channel types shared by the readers, arbiter and SPI engine
`include "AudioTx_consts.svh"

package SfmPkg;

	// --------------------------------------------------
	// Data types
	// --------------------------------------------------

	typedef logic [`SFM_ADRS_W-1:0] sfmAdrs_t;     // Flash byte address
	typedef logic [15:0]            sfmSample_t;   // One audio sample

	// Channel setup handed from the CSR to a page reader
	typedef struct packed {
		logic       en;          // Playback enable
		logic [7:0] div;         // SCK half period minus one
		logic [7:0] csHold;      // CS high time after a read
		sfmAdrs_t   startAdrs;   // First sample byte address
		sfmAdrs_t   endAdrs;     // Last sample byte address
	} sfmCfg_t;

	// --------------------------------------------------
	// SPI engine
	// --------------------------------------------------

	typedef enum logic [1:0] {
		SPI_IDLE,    // Ready for a request
		SPI_SHIFT,   // CS low, 40 bits on the wire
		SPI_HOLD     // CS high, hold time running
	} spiState_t;

endpackage

//--- verilog/SfmReqIf.sv
// Sample read request channel between reader, arbiter and SPI engine
`timescale 1ns/100ps

interface SfmReqIf import SfmPkg::*; ();

	logic       valid;    // Request pending, held until ready
	logic       ready;    // Request taken
	sfmAdrs_t   adrs;     // Byte address of the sample
	logic [7:0] div;
	logic [7:0] csHold;
	sfmSample_t rdata;    // Sample, valid with done
	logic       done;     // One cycle, transaction finished

	// Reader side, and the arbiter toward the engine
	modport requester (output valid, adrs, div, csHold, input ready, rdata, done);

	// Arbiter side facing each reader
	modport arbiter (input valid, adrs, div, csHold, output ready, rdata, done);

	// SPI engine side
	modport server (input valid, adrs, div, csHold, output ready, rdata, done);

endinterface

//--- verilog/SfmSpiArbiter.sv
// Round-robin arbiter sharing the SPI engine among the page readers
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module SfmSpiArbiter import SfmPkg::*; (
	input logic        iSCLK,
	input logic        iSRST,
	SfmReqIf.arbiter   req [`SFM_NUM],
	SfmReqIf.requester spi
);

	localparam int IdxW = (`SFM_NUM > 1) ? $clog2(`SFM_NUM) : 1;

	logic [`SFM_NUM-1:0] reqValid;
	sfmAdrs_t            reqAdrs [`SFM_NUM];
	logic [7:0]          reqDiv [`SFM_NUM];
	logic [7:0]          reqCsHold [`SFM_NUM];
	logic [`SFM_NUM-1:0] gnt;           // One-hot owner
	logic                lockQ;         // Transaction in flight
	logic [IdxW-1:0]     ownerQ;
	logic [IdxW-1:0]     ptrQ;          // First channel to look at
	logic [IdxW-1:0]     sel;
	logic                hit;

	for (genvar g = 0; g < `SFM_NUM; g++)
	begin : gPort
		assign reqValid[g]  = req[g].valid;
		assign reqAdrs[g]   = req[g].adrs;
		assign reqDiv[g]    = req[g].div;
		assign reqCsHold[g] = req[g].csHold;
		assign gnt[g]       = lockQ ? (ownerQ == IdxW'(g)) : (hit && (sel == IdxW'(g)));
		assign req[g].ready = gnt[g] & ~lockQ & spi.ready;
		assign req[g].done  = gnt[g] & spi.done;
		assign req[g].rdata = spi.rdata;
	end

	// Search from the pointer for the first pending request
	always_comb
	begin
		int idx;
		hit = 1'b0;
		sel = '0;
		for (int k = 0; k < `SFM_NUM; k++)
		begin
			idx = (int'(ptrQ) + k) % `SFM_NUM;
			if (!hit && reqValid[idx])
			begin
				hit = 1'b1;
				sel = IdxW'(idx);
			end
		end
	end

	// Same cycle forward, no added latency
	assign spi.valid  = ~lockQ & hit;
	assign spi.adrs   = reqAdrs[sel];
	assign spi.div    = reqDiv[sel];
	assign spi.csHold = reqCsHold[sel];

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			lockQ  <= 1'b0;
			ownerQ <= '0;
			ptrQ   <= '0;
		end
		else if (!lockQ && hit && spi.ready)
		begin
			lockQ  <= 1'b1;
			ownerQ <= sel;
			ptrQ   <= IdxW'((int'(sel) + 1) % `SFM_NUM);
		end
		else if (lockQ && spi.done)
			lockQ <= 1'b0;
	end

endmodule

//--- verilog/SfmSpiMaster.sv
// SPI engine for one serial flash read: command, address, two data bytes
`timescale 1ns/100ps
`include "AudioTx_consts.svh"

module SfmSpiMaster import SfmPkg::*; (
	input  logic    iSCLK,
	input  logic    iSRST,
	input  logic    spiMiso,
	output logic    spiSck,
	output logic    spiCs,
	output logic    spiMosi,
	SfmReqIf.server req
);

	spiState_t  stateQ;
	logic [7:0] divCntQ;
	logic [5:0] bitCntQ;
	logic [7:0] holdCntQ;
	logic [39:0] txQ;       // Command, address, dummy for the data phase
	logic [7:0] divQ;
	logic [7:0] holdQ;
	logic [15:0] rxQ;       // Last 16 bits from MISO
	sfmSample_t rdataQ;
	logic       doneQ;
	logic       halfEnd;
	logic       holdEnd;

	assign halfEnd = (divCntQ == divQ);
	assign holdEnd = (holdCntQ >= holdQ);

	assign req.ready = (stateQ == SPI_IDLE);
	assign req.done  = doneQ;
	assign req.rdata = rdataQ;
	assign spiMosi   = txQ[39];

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			stateQ   <= SPI_IDLE;
			spiCs    <= 1'b1;
			spiSck   <= 1'b0;
			txQ      <= '0;
			divCntQ  <= '0;
			bitCntQ  <= '0;
			holdCntQ <= '0;
			doneQ    <= 1'b0;
		end
		else
		begin
			doneQ <= 1'b0;
			case (stateQ)
				SPI_IDLE:
					if (req.valid)
					begin
						spiCs   <= 1'b0;
						txQ     <= {`SFM_READ_CMD, req.adrs, 16'h0000};
						divCntQ <= '0;
						bitCntQ <= '0;
						stateQ  <= SPI_SHIFT;
					end
				SPI_SHIFT:
					if (halfEnd)
					begin
						divCntQ <= '0;
						spiSck  <= ~spiSck;
						if (spiSck)             // Falling edge
						begin
							if (bitCntQ == 6'd39)
							begin
								spiCs    <= 1'b1;
								holdCntQ <= 8'd1;
								stateQ   <= SPI_HOLD;
							end
							else
							begin
								txQ     <= {txQ[38:0], 1'b0};
								bitCntQ <= bitCntQ + 6'd1;
							end
						end
					end
					else
						divCntQ <= divCntQ + 8'd1;
				SPI_HOLD:
					if (holdEnd)
					begin
						doneQ  <= 1'b1;
						stateQ <= SPI_IDLE;
					end
					else
						holdCntQ <= holdCntQ + 8'd1;
				default: stateQ <= SPI_IDLE;
			endcase
		end
	end

	// Data path
	always_ff @(posedge iSCLK)
	begin
		if (stateQ == SPI_IDLE && req.valid)
		begin
			divQ  <= req.div;
			holdQ <= req.csHold;
		end
		if (stateQ == SPI_SHIFT && halfEnd && !spiSck) rxQ <= {rxQ[14:0], spiMiso};  // Rising
		if (stateQ == SPI_HOLD && holdEnd) rdataQ <= {rxQ[7:0], rxQ[15:8]};  // Low byte came first
	end

endmodule

//--- verilog/UsiBusPkg.sv
// USI bus types for the CPU-side register interface
package UsiBusPkg;

	// --------------------------------------------------
	// Bus words
	// --------------------------------------------------

	// Data word on both read and write paths
	typedef logic [31:0] usiWord_t;

	// Full bus address, bit 30 flags a write
	typedef logic [31:0] usiAdrs_t;

	// --------------------------------------------------
	// Register offsets
	// --------------------------------------------------

	// Low address byte, selects a register inside the block
	typedef logic [7:0] usiCsrOfs_t;

endpackage
